//--- msx_bus_pkg.sv
// Z80 side of the cartridge slot
// Widths seen by the host and the byte driven when nothing answers
package msx_bus_pkg;

    // CPU address bus, 64 KiB space
    localparam int cpu_addr_w = 16;

    // CPU data bus
    localparam int cpu_data_w = 8;

    // Pulled-up data bus value
    // Returned for unmapped reads and for every write cycle
    localparam logic [cpu_data_w-1:0] idle_byte = 8'hFF;

endpackage

//--- cart_map_pkg.sv
// Game Master 2 mapper layout and cartridge memory addressing
package cart_map_pkg;

    // Flat memory address, same width as the memory side of the core
    localparam int mem_addr_w = 27;

    // Bank register: [3:0] ROM bank, [4] SRAM enable, [5] SRAM page
    typedef logic [5:0] bank_t;

    localparam int bank_rom_msb   = 3;  // Top bit of the ROM bank field
    localparam int bank_sram_en   = 4;  // Window maps to SRAM when set
    localparam int bank_sram_page = 5;  // Selects one of the two 4 KiB pages

    // Power-on banks for the 6000h, 8000h and A000h windows
    localparam bank_t bank1_rst = 6'd1;
    localparam bank_t bank2_rst = 6'd2;
    localparam bank_t bank3_rst = 6'd3;

    // Target of one access
    typedef enum logic [1:0] {
        sel_none = 2'd0,  // Nothing responds
        sel_rom  = 2'd1,
        sel_sram = 2'd2
    } sel_t;

    // One address word, read back through the view named by sel_t
    typedef union packed {
        struct packed {
            logic [mem_addr_w-18:0] pad;     // Always zero
            logic [3:0]             bank;    // 8 KiB ROM bank
            logic [12:0]            offset;  // Byte inside the bank
        } rom_view;
        struct packed {
            logic [mem_addr_w-14:0] pad;     // Always zero
            logic                   page;    // SRAM page
            logic [11:0]            offset;  // Byte inside the 4 KiB page
        } sram_view;
    } mem_addr_u;

endpackage

//--- req_queue.sv
`timescale 1ns/1ps

module req_queue
    import msx_bus_pkg::*;
#(
    parameter int queue_depth = 4
) (
    input  logic                  cpu_bus,
    input  logic                  rst,
    input  logic                  push,
    input  logic [cpu_addr_w-1:0] push_addr,
    input  logic [cpu_data_w-1:0] push_wdata,
    input  logic                  push_wr,
    input  logic                  pop,
    output logic                  head_valid,
    output logic [cpu_addr_w-1:0] head_addr,
    output logic [cpu_data_w-1:0] head_wdata,
    output logic                  head_wr,
    output logic                  credit_ret
);

    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w = $clog2(queue_depth + 1);

    logic [cpu_addr_w-1:0] addr_mem  [queue_depth];  // Request payload, no reset
    logic [cpu_data_w-1:0] wdata_mem [queue_depth];
    logic                  wr_mem    [queue_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;   // Occupancy
    logic             do_pop;  // Pop of a real entry

    assign head_valid = (count != '0);
    assign head_addr  = addr_mem[rd_ptr];   // Head is read straight from storage
    assign head_wdata = wdata_mem[rd_ptr];
    assign head_wr    = wr_mem[rd_ptr];
    assign do_pop     = pop && head_valid;
    assign credit_ret = do_pop;             // One credit back per popped request

    always_ff @(posedge cpu_bus) begin
        if (push) begin
            addr_mem[wr_ptr]  <= push_addr;
            wdata_mem[wr_ptr] <= push_wdata;
            wr_mem[wr_ptr]    <= push_wr;
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // Both or neither, level unchanged
            endcase
        end
    end

    // Host spent a credit it did not hold
    a_no_push_full: assert property (@(posedge cpu_bus) disable iff (rst)
        push |-> (count != cnt_w'(queue_depth)));

    // Sequencer only pops what the queue offered
    a_no_pop_empty: assert property (@(posedge cpu_bus) disable iff (rst)
        pop |-> head_valid);

endmodule

//--- wait_timer.sv
`timescale 1ns/1ps

module wait_timer #(
    parameter int wait_cycles = 2
) (
    input  logic cpu_bus,
    input  logic rst,
    input  logic start,
    output logic done
);

    localparam int cnt_w = (wait_cycles > 0) ? $clog2(wait_cycles + 1) : 1;

    logic [cnt_w-1:0] cnt;   // Remaining wait states
    logic             busy;  // Counting an access

    // Pulse on the cycle the count has run out
    assign done = busy && (cnt == '0);

    always_ff @(posedge cpu_bus) begin
        if (rst) begin
            cnt  <= '0;
            busy <= 1'b0;
        end else if (start) begin
            cnt  <= cnt_w'(wait_cycles);  // Reload, also restarts a running count
            busy <= 1'b1;
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;  // Done seen this cycle
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

//--- slot_access_fsm.sv
`timescale 1ns/1ps

module slot_access_fsm (
    input  logic cpu_bus,
    input  logic rst,
    input  logic q_valid,
    input  logic tmr_done,
    output logic q_pop,
    output logic latch_en,
    output logic tmr_start,
    output logic bus_commit,
    output logic rsp_valid
);

    localparam logic [2:0] st_idle   = 3'd0;  // Waiting for a queued request
    localparam logic [2:0] st_latch  = 3'd1;  // Request held, mapper settling
    localparam logic [2:0] st_wait   = 3'd2;  // Wait states
    localparam logic [2:0] st_access = 3'd3;  // Memory strobe
    localparam logic [2:0] st_resp   = 3'd4;  // Data back to the host

    logic [2:0] state;
    logic [2:0] state_nxt;

    // Pop, latch and timer start all fire together on the head request
    assign q_pop      = (state == st_idle) && q_valid;
    assign latch_en   = q_pop;       // Head captured before the pointer moves
    assign tmr_start  = q_pop;       // Wait states counted from the pop
    assign bus_commit = (state == st_access);
    assign rsp_valid  = (state == st_resp);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (q_valid) begin
                    state_nxt = st_latch;
                end
            end
            st_latch: begin
                // Zero wait states finish here already
                state_nxt = tmr_done ? st_access : st_wait;
            end
            st_wait: begin
                if (tmr_done) begin
                    state_nxt = st_access;
                end
            end
            st_access: state_nxt = st_resp;
            st_resp:   state_nxt = st_idle;
            default:   state_nxt = st_idle;  // Unused codes recover
        endcase
    end

    always_ff @(posedge cpu_bus) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Every memory strobe is answered exactly once, on the next cycle
    a_commit_rsp: assert property (@(posedge cpu_bus) disable iff (rst)
        bus_commit |-> !rsp_valid ##1 (rsp_valid && !bus_commit));

    // Timer only finishes while an access is being stretched
    a_done_window: assert property (@(posedge cpu_bus) disable iff (rst)
        tmr_done |-> (state == st_latch || state == st_wait));

endmodule

//--- gm2_bank_mapper.sv
`timescale 1ns/1ps

module gm2_bank_mapper
    import msx_bus_pkg::*;
    import cart_map_pkg::*;
(
    input  logic                  cpu_bus,
    input  logic                  rst,
    input  logic [cpu_addr_w-1:0] addr,
    input  logic [cpu_data_w-1:0] wdata,
    input  logic                  wr,
    input  logic                  commit,
    output sel_t                  sel,
    output mem_addr_u             mem_addr,
    output logic                  sram_we
);

    bank_t bank1;     // 6000h window
    bank_t bank2;     // 8000h window
    bank_t bank3;     // A000h window
    bank_t win_bank;  // Bank of the window addr falls in

    logic in_window;  // 4000h-BFFFh
    logic b_page;     // Bxxx is the only SRAM write range
    logic sram_hit;

    assign in_window = addr[15] ^ addr[14];
    assign b_page    = (addr[15:12] == 4'hB);

    // SRAM takes reads anywhere in its window, writes only in Bxxx
    assign sram_hit = in_window && win_bank[bank_sram_en] && (!wr || b_page);
    assign sram_we  = sram_hit && wr;

    // Bank switch on any committed register write, even with the window on SRAM
    always_ff @(posedge cpu_bus) begin
        if (rst) begin
            bank1 <= bank1_rst;
            bank2 <= bank2_rst;
            bank3 <= bank3_rst;
        end else if (commit && wr) begin
            case (addr[15:12])
                4'h6:    bank1 <= wdata[5:0];
                4'h8:    bank2 <= wdata[5:0];
                4'hA:    bank3 <= wdata[5:0];
                default: ;  // Not a register
            endcase
        end
    end

    always_comb begin
        case (addr[15:13])
            3'b010:  win_bank = '0;     // 4000h fixed to bank 0
            3'b011:  win_bank = bank1;
            3'b100:  win_bank = bank2;
            default: win_bank = bank3;  // A000h and anything outside the window
        endcase
    end

    always_comb begin
        sel      = sel_none;
        mem_addr = '0;
        if (sram_hit) begin
            sel                       = sel_sram;
            mem_addr.sram_view.page   = win_bank[bank_sram_page];
            mem_addr.sram_view.offset = addr[11:0];  // 4 KiB mirrored twice per window
        end else if (in_window && !wr) begin
            sel                      = sel_rom;
            mem_addr.rom_view.bank   = win_bank[bank_rom_msb:0];
            mem_addr.rom_view.offset = addr[12:0];
        end
    end

    a_we_sram: assert property (@(posedge cpu_bus) disable iff (rst)
        sram_we |-> (sel == sel_sram));

endmodule

//--- cart_memory.sv
`timescale 1ns/1ps

module cart_memory
    import msx_bus_pkg::*;
    import cart_map_pkg::*;
#(
    parameter int rom_bank_bits = 4
) (
    input  logic                    cpu_bus,
    input  sel_t                    sel,
    input  mem_addr_u               mem_addr,
    input  logic [cpu_data_w-1:0]   wdata,
    input  logic                    sram_we,
    input  logic                    commit,
    input  logic                    load_valid,
    input  logic [rom_bank_bits+12:0] load_addr,
    input  logic [cpu_data_w-1:0]   load_data,
    output logic [cpu_data_w-1:0]   rdata
);

    localparam int rom_aw  = rom_bank_bits + 13;  // 8 KiB per bank
    localparam int sram_aw = 13;                  // Two 4 KiB pages

    logic [cpu_data_w-1:0] rom  [2**rom_aw];
    logic [cpu_data_w-1:0] sram [2**sram_aw];

    logic [rom_aw-1:0]  rom_idx;
    logic [sram_aw-1:0] sram_idx;

    // Bank field sized to the image, upper banks alias
    assign rom_idx  = rom_aw'({mem_addr.rom_view.bank, mem_addr.rom_view.offset});
    assign sram_idx = {mem_addr.sram_view.page, mem_addr.sram_view.offset};

    // Image loader, one byte per cycle
    always_ff @(posedge cpu_bus) begin
        if (load_valid) begin
            rom[load_addr] <= load_data;
        end
    end

    // Battery SRAM write port
    always_ff @(posedge cpu_bus) begin
        if (commit && sram_we) begin
            sram[sram_idx] <= wdata;
        end
    end

    // Response byte, valid in the cycle after commit
    always_ff @(posedge cpu_bus) begin
        if (commit) begin
            if (sram_we) begin
                rdata <= idle_byte;  // Write cycle
            end else begin
                case (sel)
                    sel_rom:  rdata <= rom[rom_idx];
                    sel_sram: rdata <= sram[sram_idx];
                    default:  rdata <= idle_byte;  // Unmapped or ignored write
                endcase
            end
        end
    end

endmodule

//--- cart_slot_top.sv
`timescale 1ns/1ps

module cart_slot_top
    import msx_bus_pkg::*;
    import cart_map_pkg::*;
#(
    parameter int queue_depth   = 4,  // Also the host's credit count
    parameter int wait_cycles   = 2,
    parameter int rom_bank_bits = 4   // 16 banks, 128 KiB image
) (
    input  logic                      cpu_bus,
    input  logic                      rst,
    input  logic                      req_valid,
    input  logic [cpu_addr_w-1:0]     req_addr,
    input  logic [cpu_data_w-1:0]     req_wdata,
    input  logic                      req_wr,
    input  logic                      load_valid,
    input  logic [rom_bank_bits+12:0] load_addr,
    input  logic [cpu_data_w-1:0]     load_data,
    output logic                      credit_ret,
    output logic                      rsp_valid,
    output logic [cpu_data_w-1:0]     rsp_rdata
);

    logic                  q_valid;
    logic [cpu_addr_w-1:0] head_addr;
    logic [cpu_data_w-1:0] head_wdata;
    logic                  head_wr;
    logic                  q_pop;
    logic                  latch_en;
    logic                  tmr_start;
    logic                  tmr_done;
    logic                  bus_commit;

    logic [cpu_addr_w-1:0] lat_addr;   // Request in the memory stage
    logic [cpu_data_w-1:0] lat_wdata;
    logic                  lat_wr;

    sel_t      sel;
    mem_addr_u mem_addr;
    logic      sram_we;

    req_queue #(
        .queue_depth (queue_depth)
    ) req_queue_i (
        .cpu_bus    (cpu_bus),
        .rst        (rst),
        .push       (req_valid),  // Credits guarantee room
        .push_addr  (req_addr),
        .push_wdata (req_wdata),
        .push_wr    (req_wr),
        .pop        (q_pop),
        .head_valid (q_valid),
        .head_addr  (head_addr),
        .head_wdata (head_wdata),
        .head_wr    (head_wr),
        .credit_ret (credit_ret)
    );

    slot_access_fsm slot_access_fsm_i (
        .cpu_bus    (cpu_bus),
        .rst        (rst),
        .q_valid    (q_valid),
        .tmr_done   (tmr_done),
        .q_pop      (q_pop),
        .latch_en   (latch_en),
        .tmr_start  (tmr_start),
        .bus_commit (bus_commit),
        .rsp_valid  (rsp_valid)
    );

    wait_timer #(
        .wait_cycles (wait_cycles)
    ) wait_timer_i (
        .cpu_bus (cpu_bus),
        .rst     (rst),
        .start   (tmr_start),
        .done    (tmr_done)
    );

    // Held stable from LATCH through ACCESS for the mapper
    always_ff @(posedge cpu_bus) begin
        if (latch_en) begin
            lat_addr  <= head_addr;
            lat_wdata <= head_wdata;
            lat_wr    <= head_wr;
        end
    end

    gm2_bank_mapper gm2_bank_mapper_i (
        .cpu_bus  (cpu_bus),
        .rst      (rst),
        .addr     (lat_addr),
        .wdata    (lat_wdata),
        .wr       (lat_wr),
        .commit   (bus_commit),
        .sel      (sel),
        .mem_addr (mem_addr),
        .sram_we  (sram_we)
    );

    cart_memory #(
        .rom_bank_bits (rom_bank_bits)
    ) cart_memory_i (
        .cpu_bus    (cpu_bus),
        .sel        (sel),
        .mem_addr   (mem_addr),
        .wdata      (lat_wdata),
        .sram_we    (sram_we),
        .commit     (bus_commit),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .rdata      (rsp_rdata)  // Registered, lines up with rsp_valid
    );

endmodule

//--- tb_cart_slot.sv
`timescale 1ns/1ps

module tb_cart_slot
    import msx_bus_pkg::*;
();

    localparam int queue_depth   = 4;
    localparam int wait_cycles   = 2;
    localparam int rom_bank_bits = 4;
    localparam int rom_aw        = rom_bank_bits + 13;
    localparam int rom_bytes     = 2 ** rom_aw;
    localparam int sram_n        = 8;  // SRAM bytes per pass
    localparam int total_reqs    = 8 + 44 + 70 + 24 + 16 + 400;  // Per test, in order
    localparam int cycle_limit   = rom_bytes + 20 * total_reqs + 2000;

    logic                  cpu_bus = 1'b0;
    logic                  rst;
    logic                  req_valid;
    logic [cpu_addr_w-1:0] req_addr;
    logic [cpu_data_w-1:0] req_wdata;
    logic                  req_wr;
    logic                  load_valid;
    logic [rom_aw-1:0]     load_addr;
    logic [cpu_data_w-1:0] load_data;
    logic                  credit_ret;
    logic                  rsp_valid;
    logic [cpu_data_w-1:0] rsp_rdata;

    // Reference copy of the cartridge
    logic [7:0] m_rom     [rom_bytes];
    logic [7:0] m_sram    [8192];
    bit         m_sram_ok [8192];  // Byte written since start
    logic [5:0] m_bank    [4];     // Entry 0 is the fixed 4000h window

    int          exp_q      [$];  // Expected byte or -1 when unknown
    logic [15:0] exp_addr_q [$];

    integer      seed = 32'h5da54ff0;
    logic [31:0] rnd;
    logic [11:0] offs [sram_n];
    logic [3:0]  plain_pages [5] = '{4'h4, 4'h5, 4'h7, 4'h9, 4'hB};  // No register here

    int credits;
    int min_credits;
    int sent_count;
    int rsp_count;
    int ret_count;
    int errors;
    int tests_run;
    int cycle_count = 0;

    cart_slot_top #(
        .queue_depth   (queue_depth),
        .wait_cycles   (wait_cycles),
        .rom_bank_bits (rom_bank_bits)
    ) cart_slot_top_i (
        .cpu_bus    (cpu_bus),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wr     (req_wr),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .credit_ret (credit_ret),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata)
    );

    initial begin
        forever #20 cpu_bus = ~cpu_bus;  // 40 ns period
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // GM2 rules applied in request order with the expected byte queued
    function automatic void model_access(input logic [15:0] addr, input logic [7:0] wdata,
                                         input logic wr);
        logic        in_win;
        logic [1:0]  win;
        logic [5:0]  wb;
        logic [12:0] sidx;
        int          exp_v;
        in_win = (addr >= 16'h4000) && (addr < 16'hC000);
        win    = {addr[15], addr[13]};  // 4000h, 6000h, 8000h, A000h
        wb     = m_bank[win];
        sidx   = {wb[5], addr[11:0]};   // Page bit on top of 4 KiB
        exp_v  = int'(idle_byte);
        if (wr) begin
            if (in_win && wb[4] && addr[15:12] == 4'hB) begin
                m_sram[sidx]    = wdata;
                m_sram_ok[sidx] = 1'b1;
            end
            if (in_win && win != 2'd0 && !addr[12]) begin
                m_bank[win] = wdata[5:0];  // 6xxx, 8xxx, Axxx
            end
        end else if (in_win && wb[4]) begin
            exp_v = m_sram_ok[sidx] ? int'(m_sram[sidx]) : -1;
        end else if (in_win) begin
            exp_v = int'(m_rom[{wb[3:0], addr[12:0]}]);
        end
        exp_q.push_back(exp_v);
        exp_addr_q.push_back(addr);
    endfunction

    function automatic logic [15:0] win_addr(input logic [1:0] win, input logic [12:0] off);
        return {{1'b0, win} + 3'd2, off};
    endfunction

    // Books the credit popped at the coming edge, then moves one cycle on
    task automatic next_cycle();
        if (credit_ret) begin
            credits++;
            ret_count++;
        end
        if (credits > queue_depth || credits < 0) begin
            $display("Error: host holds %0d credits at %0t, outside 0 to %0d",
                     credits, $time, queue_depth);
            errors++;
        end
        @(negedge cpu_bus);
    endtask

    task automatic send(input logic [15:0] addr, input logic [7:0] wdata, input logic wr);
        while (credits == 0) begin
            next_cycle();
        end
        req_valid = 1'b1;
        req_addr  = addr;
        req_wdata = wdata;
        req_wr    = wr;
        credits--;  // Spent with req_valid
        if (credits < min_credits) begin
            min_credits = credits;
        end
        sent_count++;
        model_access(addr, wdata, wr);
        next_cycle();
        req_valid = 1'b0;
    endtask

    task automatic finish_test(input string name, input int err_base);
        while (rsp_count != sent_count) begin
            next_cycle();  // Drain the outstanding responses
        end
        check_value(ret_count, sent_count, "credit_ret pulses against requests");
        tests_run++;
        $display("Test %0d %s: %s, %0d requests so far", tests_run, name,
                 (errors == err_base) ? "ok" : "FAILED", sent_count);
    endtask

    always @(negedge cpu_bus) begin : rsp_monitor
        int          exp_v;
        logic [15:0] exp_a;
        if (!rst && rsp_valid) begin
            if (exp_q.size() == 0) begin
                $display("Error: response at %0t with no request outstanding", $time);
                errors++;
            end else begin
                exp_v = exp_q.pop_front();
                exp_a = exp_addr_q.pop_front();
                rsp_count++;
                if (exp_v >= 0) begin  // Unwritten SRAM is not compared
                    check_value({24'd0, rsp_rdata}, exp_v,
                                $sformatf("response for address %04h", exp_a));
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < cycle_limit) begin
            @(posedge cpu_bus);
            cycle_count++;
        end
        $display("Error: run exceeded %0d cycles without finishing", cycle_limit);
        $display("Regression failed");
        $finish;
    end

    initial begin : stimulus
        int err_base;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        req_wr      = 1'b0;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        credits     = queue_depth;
        min_credits = queue_depth;
        sent_count  = 0;
        rsp_count   = 0;
        ret_count   = 0;
        errors      = 0;
        tests_run   = 0;
        for (int b = 0; b < 4; b++) begin
            m_bank[b] = 6'(b);  // Power-on banks
        end
        repeat (2) @(negedge cpu_bus);
        rst = 1'b0;

        // Image load at one byte per cycle
        for (int i = 0; i < rom_bytes; i++) begin
            rnd        = $random(seed);
            load_valid = 1'b1;
            load_addr  = rom_aw'(i);
            load_data  = rnd[7:0];
            m_rom[i]   = rnd[7:0];
            next_cycle();
        end
        load_valid = 1'b0;

        err_base = errors;
        for (int w = 0; w < 4; w++) begin
            rnd = $random(seed);
            send(win_addr(2'(w), 13'h0000), 8'h00, 1'b0);
            send(win_addr(2'(w), rnd[12:0]), 8'h00, 1'b0);
        end
        finish_test("power-on banks", err_base);

        err_base = errors;
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 3; k++) begin
                rnd = $random(seed);
                send({4'(6 + 2 * k), rnd[11:0]}, {rnd[31:30], 2'b00, rnd[3:0]}, 1'b1);
            end
            for (int w = 0; w < 4; w++) begin
                rnd = $random(seed);
                send(win_addr(2'(w), rnd[12:0]), 8'h00, 1'b0);
                send(win_addr(2'(w), rnd[25:13]), 8'h00, 1'b0);
            end
        end
        finish_test("bank switching", err_base);

        err_base = errors;
        send(16'hA000, 8'h10, 1'b1);  // Bank3 on SRAM page 0
        for (int i = 0; i < sram_n; i++) begin
            rnd     = $random(seed);
            offs[i] = rnd[11:0];
            send({4'hB, offs[i]}, rnd[23:16], 1'b1);
        end
        for (int i = 0; i < sram_n; i++) begin
            send({4'hB, offs[i]}, 8'h00, 1'b0);
            send({4'hA, offs[i]}, 8'h00, 1'b0);  // Lower half mirrors the page
        end
        send(16'hA000, 8'h30, 1'b1);  // Page 1
        for (int i = 0; i < sram_n; i++) begin
            rnd = $random(seed);
            send({4'hB, offs[i]}, rnd[7:0], 1'b1);
        end
        for (int i = 0; i < sram_n; i++) begin
            send({4'hB, offs[i]}, 8'h00, 1'b0);
        end
        send(16'hA000, 8'h10, 1'b1);  // Page 0 must be untouched
        for (int i = 0; i < sram_n; i++) begin
            send({4'hA, offs[i]}, 8'h00, 1'b0);
        end
        send(16'h8000, 8'h10, 1'b1);  // Bank2 also on page 0
        for (int i = 0; i < sram_n; i++) begin
            rnd = $random(seed);
            send({4'h9, offs[i]}, rnd[7:0], 1'b1);  // Outside Bxxx so dropped
        end
        for (int i = 0; i < sram_n; i++) begin
            send({4'h8, offs[i]}, 8'h00, 1'b0);
        end
        send(16'h8000, 8'h02, 1'b1);
        send(16'hA000, 8'h03, 1'b1);
        finish_test("SRAM pages", err_base);

        err_base = errors;
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            send({rnd[14], rnd[14:0]}, rnd[23:16], rnd[24]);  // Top bits equal so unmapped
        end
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            send({plain_pages[i % 5], rnd[11:0]}, rnd[23:16], 1'b1);
            send({plain_pages[i % 5], rnd[11:0]}, 8'h00, 1'b0);  // ROM byte unchanged
        end
        finish_test("idle byte and read-only ROM", err_base);

        err_base    = errors;
        min_credits = credits;
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            send(win_addr(rnd[1:0], rnd[14:2]), 8'h00, 1'b0);  // Back to back
        end
        check_value(min_credits, 0, "lowest credit count during burst");
        finish_test("burst", err_base);

        err_base = errors;
        for (int i = 0; i < 400; i++) begin
            rnd = $random(seed);
            if (rnd[31:29] == 3'd0) begin
                next_cycle();  // Occasional idle gap
            end
            send(rnd[15:0], rnd[23:16], rnd[25:24] == 2'b00);
        end
        finish_test("random", err_base);

        $display("Summary: %0d tests, %0d requests, %0d responses, %0d credit returns, %0d errors",
                 tests_run, sent_count, rsp_count, ret_count, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
msx_bus_pkg.sv
cart_map_pkg.sv
req_queue.sv
wait_timer.sv
slot_access_fsm.sv
gm2_bank_mapper.sv
cart_memory.sv
cart_slot_top.sv
tb_cart_slot.sv

//--- run.sh
#!/bin/sh
# Build and run the cartridge slot testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_cart_slot \
    -Mdir obj_dir \
    -o sim_cart_slot

# Simulator status is not trusted, the log decides
./obj_dir/sim_cart_slot 2>&1 | tee sim.log

if grep -q "^Regression passed$" sim.log; then
    exit 0
else
    exit 1
fi
